// File: rtl/nes_bus_pkg.sv
package nes_bus_pkg;

	// Bus payloads
	typedef logic [15:0] addr_t;      // CPU address bus
	typedef logic [7:0]  byte_t;      // Data bus byte
	typedef logic [4:0]  pad_data_t;  // Serial bits from one controller port
	typedef logic [2:0]  pad_strobe_t; // OUT0..OUT2 pins of the 2A03

	// Master clock divider
	localparam int CPU_DIV_W = 5; // Wide enough for PAL's 16 as well
	localparam logic [CPU_DIV_W-1:0] CPU_DIV_NTSC = 5'd12; // 21.477 MHz / 12

	// Writing the page number here starts the OAM copy
	localparam addr_t OAM_DMA_ADDR = 16'h4014;

	// Every sprite DMA write lands on OAMDATA
	localparam addr_t OAM_DATA_ADDR = 16'h2004;

	// Controller ports
	localparam addr_t JOY1_ADDR = 16'h4016; // Strobe on write, port 1 on read
	localparam addr_t JOY2_ADDR = 16'h4017; // Port 2 on read

	// Upper 11 address bits of the $4000-$401F register window
	localparam logic [10:0] IO_PAGE = 11'b0100_0000_000;

endpackage

// File: rtl/cpu_clock_gen.sv
`timescale 1ns/1ps

// CPU clock enable from the master clock
// Cyc 123456789ABC123456789ABC
// CPU -----------C-----------C
module cpu_clock_gen #(
	parameter logic [nes_bus_pkg::CPU_DIV_W-1:0] cpu_div = nes_bus_pkg::CPU_DIV_NTSC
) (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,    // One clk per CPU cycle
	output logic put_cycle, // 1 = odd/put, 0 = even/get
	output logic get_ce,    // Enable at the end of a get cycle
	output logic put_ce     // Enable at the end of a put cycle
);
	import nes_bus_pkg::*;

	logic [CPU_DIV_W-1:0] div_cnt; // Master clocks into this CPU cycle, counted from 1

	// Fire at the top of the count
	assign cpu_ce = (div_cnt == cpu_div);

	// Phase-qualified enables for the DMA and APU side
	assign get_ce = cpu_ce && !put_cycle;
	assign put_ce = cpu_ce && put_cycle;

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= CPU_DIV_W'(1);
		end else if (cpu_ce) begin
			div_cnt <= CPU_DIV_W'(1); // Wrap back to the first master clock
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Get/put alternate on every CPU cycle
	// The first cycle after reset counts as odd
	always_ff @(posedge clk) begin
		if (reset) begin
			put_cycle <= 1'b1;
		end else if (cpu_ce) begin
			put_cycle <= !put_cycle;
		end
	end

endmodule

// File: rtl/sprite_dmc_dma.sv
`timescale 1ns/1ps

// OAM page copy and DMC sample fetch
// Sprite reads happen on get cycles, writes to $2004 on put cycles
// A DMC fetch steals one get cycle, the put cycle after it stays idle
module sprite_dmc_dma (
	input  logic               clk,
	input  logic               reset,
	input  logic               cpu_ce,
	input  logic               put_cycle,
	input  logic               get_ce,
	input  logic               put_ce,
	input  nes_bus_pkg::addr_t cpu_addr,
	input  logic               cpu_rnw,
	input  nes_bus_pkg::byte_t cpu_dout,
	input  logic               dmc_trigger,  // Held by the DMC until it sees dmc_ack
	input  nes_bus_pkg::addr_t dmc_dma_addr,
	input  nes_bus_pkg::byte_t bus_rdata,    // Byte read by the DMA this cycle
	output nes_bus_pkg::addr_t dma_addr,
	output logic               dma_active,   // DMA owns the bus this cycle
	output logic               dma_read,     // 1 = read, 0 = write
	output nes_bus_pkg::byte_t dma_wdata,
	output logic               dmc_ack,
	output logic               pause_cpu
);
	import nes_bus_pkg::*;

	// Bit 0 halts the CPU, bit 1 means the copy loop is running
	localparam logic [1:0] SPR_IDLE = 2'b00;
	localparam logic [1:0] SPR_WAIT = 2'b01; // Halted, waiting for a CPU read cycle
	localparam logic [1:0] SPR_COPY = 2'b11;

	logic [1:0] spr_state;
	logic       dmc_state;   // DMC fetch owns the next get cycle
	logic       spr_full;    // Byte waiting to go to $2004
	addr_t      spr_addr;    // Source address, page from the $4014 write
	byte_t      spr_data;
	logic       spr_trigger;
	logic       spr_read;
	logic       spr_write;

	assign spr_trigger = cpu_ce && !cpu_rnw && (cpu_addr == OAM_DMA_ADDR);

	// The DMC may drop its request before the fetch, so ack follows the trigger
	assign dmc_ack = dmc_state && !put_cycle && dmc_trigger;

	assign spr_read  = (spr_state == SPR_COPY) && !put_cycle && !dmc_ack; // DMC wins the get slot
	assign spr_write = (spr_state == SPR_COPY) && put_cycle && spr_full;

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= SPR_IDLE;
			dmc_state <= 1'b0;
			spr_full  <= 1'b0;
		end else begin
			// DMC request is taken on a put cycle while the CPU reads
			if (!dmc_state && dmc_trigger && cpu_rnw && put_ce) begin
				dmc_state <= 1'b1;
			end else if (dmc_state && put_ce) begin
				dmc_state <= 1'b0;
			end

			case (spr_state)
				SPR_IDLE: if (spr_trigger) spr_state <= SPR_WAIT;
				SPR_WAIT: if (get_ce && cpu_rnw) spr_state <= SPR_COPY; // Alignment
				SPR_COPY: begin
					// Low byte wrapped and the last byte just went out
					if (put_ce && spr_full && spr_addr[7:0] == 8'h00) spr_state <= SPR_IDLE;
				end
				default: spr_state <= SPR_IDLE;
			endcase

			if (spr_read && get_ce) begin
				spr_full <= 1'b1;
			end else if (put_ce) begin
				spr_full <= 1'b0; // Written, or idle after a DMC steal
			end
		end
	end

	always_ff @(posedge clk) begin
		if (spr_state == SPR_IDLE && spr_trigger) begin
			spr_addr <= {cpu_dout, 8'h00};
		end else if (spr_read && get_ce) begin
			spr_addr[7:0] <= spr_addr[7:0] + 8'd1;
		end
		if (spr_read && cpu_ce) spr_data <= bus_rdata; // Held for the put cycle
	end

	assign pause_cpu  = spr_state[0] || dmc_trigger || dmc_state;
	assign dma_active = dmc_ack || spr_read || spr_write;
	assign dma_read   = !put_cycle;
	assign dma_wdata  = spr_data;
	assign dma_addr   = dmc_ack ? dmc_dma_addr : (put_cycle ? OAM_DATA_ADDR : spr_addr);

endmodule

// File: rtl/cpu_bus_mux.sv
`timescale 1ns/1ps

// External side of the 2A03 bus
// Picks the master, drives the strobes, returns read data, handles $4016/$4017
module cpu_bus_mux (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     cpu_ce,
	input  logic                     put_ce,
	input  nes_bus_pkg::addr_t       cpu_addr,
	input  logic                     cpu_rnw,
	input  nes_bus_pkg::byte_t       cpu_dout,
	input  nes_bus_pkg::addr_t       dma_addr,
	input  logic                     dma_active,
	input  logic                     dma_read,
	input  nes_bus_pkg::byte_t       dma_wdata,
	input  nes_bus_pkg::byte_t       mem_din,
	input  nes_bus_pkg::pad_data_t   joypad1_data,
	input  nes_bus_pkg::pad_data_t   joypad2_data,
	output nes_bus_pkg::byte_t       bus_rdata,   // Byte the current master reads
	output nes_bus_pkg::byte_t       cpu_din,
	output nes_bus_pkg::addr_t       mem_addr,
	output logic                     mem_read,
	output logic                     mem_write,
	output nes_bus_pkg::byte_t       mem_wdata,
	output nes_bus_pkg::pad_strobe_t joypad_out,  // Controller strobe pins
	output logic [1:0]               joypad_clock // One clk per read of each port
);
	import nes_bus_pkg::*;

	logic        io_cs;
	logic        joy1_cs;
	logic        joy2_cs;
	logic        cpu_rd;    // CPU owns the bus and reads
	logic        cpu_wr;
	logic [2:0]  pad_hi;    // Undriven upper bits of a pad read
	byte_t       open_bus;  // Last value seen on the data bus
	pad_strobe_t joy_latch;

	// DMA takes the bus whole, otherwise the CPU drives it
	assign mem_addr  = dma_active ? dma_addr : cpu_addr;
	assign mem_read  = dma_active ? dma_read : cpu_rnw;
	assign mem_write = dma_active ? !dma_read : !cpu_rnw;
	assign mem_wdata = dma_active ? dma_wdata : cpu_dout;

	assign cpu_rd = !dma_active && cpu_rnw;
	assign cpu_wr = !dma_active && !cpu_rnw;

	// Controller ports sit in the $4000-$401F window
	assign io_cs   = (mem_addr[15:5] == IO_PAGE);
	assign joy1_cs = io_cs && (mem_addr[4:0] == JOY1_ADDR[4:0]);
	assign joy2_cs = io_cs && (mem_addr[4:0] == JOY2_ADDR[4:0]);

	// Pads drive only D0-D4
	// The CPU sees the decayed open bus above them, the DMA sees the memory side
	assign pad_hi = dma_active ? mem_din[7:5] : open_bus[7:5];

	always_comb begin
		if (joy1_cs && mem_read) begin
			bus_rdata = {pad_hi, joypad1_data};
		end else if (joy2_cs && mem_read) begin
			bus_rdata = {pad_hi, joypad2_data};
		end else begin
			bus_rdata = mem_din;
		end
	end

	assign cpu_din = bus_rdata; // CPU data input follows the shared read path

	// Bus capacitance keeps the last driven byte
	always_ff @(posedge clk) begin
		open_bus <= mem_write ? mem_wdata : bus_rdata;
	end

	// $4016 write sets OUT0-2, pins move on the next put edge
	always_ff @(posedge clk) begin
		if (reset) begin
			joy_latch    <= '0;
			joypad_out   <= '0;
			joypad_clock <= 2'b00;
		end else begin
			if (put_ce) joypad_out <= joy_latch;
			if (joy1_cs && cpu_wr) begin
				joy_latch <= cpu_dout[2:0];
				if (put_ce) joypad_out <= cpu_dout[2:0]; // Write lands on a put cycle
			end
			// Shift the pad once per completed CPU read of its port
			joypad_clock <= {joy2_cs && cpu_rd && cpu_ce, joy1_cs && cpu_rd && cpu_ce};
		end
	end

endmodule

// File: rtl/nes_bus_top.sv
`timescale 1ns/1ps

// 2A03 bus side between the CPU core and the external bus
module nes_bus_top #(
	parameter logic [nes_bus_pkg::CPU_DIV_W-1:0] cpu_div = nes_bus_pkg::CPU_DIV_NTSC
) (
	input  logic                     clk,
	input  logic                     reset,
	input  nes_bus_pkg::addr_t       cpu_addr,
	input  logic                     cpu_rnw,
	input  nes_bus_pkg::byte_t       cpu_dout,
	input  logic                     dmc_trigger,
	input  nes_bus_pkg::addr_t       dmc_dma_addr,
	input  nes_bus_pkg::byte_t       mem_din,
	input  nes_bus_pkg::pad_data_t   joypad1_data,
	input  nes_bus_pkg::pad_data_t   joypad2_data,
	output logic                     cpu_ce,       // CPU core enable
	output logic                     pause_cpu,    // RDY low to the core
	output nes_bus_pkg::byte_t       cpu_din,
	output logic                     dmc_ack,
	output nes_bus_pkg::addr_t       mem_addr,
	output logic                     mem_read,
	output logic                     mem_write,
	output nes_bus_pkg::byte_t       mem_wdata,
	output nes_bus_pkg::pad_strobe_t joypad_out,
	output logic [1:0]               joypad_clock
);
	import nes_bus_pkg::*;

	logic  put_cycle;
	logic  get_ce;
	logic  put_ce;
	addr_t dma_addr;
	logic  dma_active;
	logic  dma_read;
	byte_t dma_wdata;
	byte_t bus_rdata; // Read data back to the DMA engine

	cpu_clock_gen #(.cpu_div(cpu_div)) u_clock_gen (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.put_cycle (put_cycle),
		.get_ce    (get_ce),
		.put_ce    (put_ce)
	);

	sprite_dmc_dma u_dma (
		.clk          (clk),
		.reset        (reset),
		.cpu_ce       (cpu_ce),
		.put_cycle    (put_cycle),
		.get_ce       (get_ce),
		.put_ce       (put_ce),
		.cpu_addr     (cpu_addr),
		.cpu_rnw      (cpu_rnw),
		.cpu_dout     (cpu_dout),
		.dmc_trigger  (dmc_trigger),
		.dmc_dma_addr (dmc_dma_addr),
		.bus_rdata    (bus_rdata),
		.dma_addr     (dma_addr),
		.dma_active   (dma_active),
		.dma_read     (dma_read),
		.dma_wdata    (dma_wdata),
		.dmc_ack      (dmc_ack),
		.pause_cpu    (pause_cpu)
	);

	cpu_bus_mux u_bus (
		.clk          (clk),
		.reset        (reset),
		.cpu_ce       (cpu_ce),
		.put_ce       (put_ce),
		.cpu_addr     (cpu_addr),
		.cpu_rnw      (cpu_rnw),
		.cpu_dout     (cpu_dout),
		.dma_addr     (dma_addr),
		.dma_active   (dma_active),
		.dma_read     (dma_read),
		.dma_wdata    (dma_wdata),
		.mem_din      (mem_din),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.bus_rdata    (bus_rdata),
		.cpu_din      (cpu_din),
		.mem_addr     (mem_addr),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_wdata    (mem_wdata),
		.joypad_out   (joypad_out),
		.joypad_clock (joypad_clock)
	);

endmodule

// File: tb/tb_nes_bus.sv
`timescale 1ns/1ps

module tb_nes_bus;
	import nes_bus_pkg::*;

	localparam int TIMEOUT_CLKS = 20000; // Two page copies of ~520 CPU cycles, 12 clocks each, plus margin

	logic        clk = 1'b0;
	logic        reset;
	logic [15:0] cpu_addr;
	logic        cpu_rnw;
	logic [7:0]  cpu_dout;
	logic        dmc_trigger;
	logic [15:0] dmc_dma_addr;
	logic [7:0]  mem_din;
	logic [4:0]  joypad1_data;
	logic [4:0]  joypad2_data;
	logic        cpu_ce;
	logic        pause_cpu;
	logic [7:0]  cpu_din;
	logic        dmc_ack;
	logic [15:0] mem_addr;
	logic        mem_read;
	logic        mem_write;
	logic [7:0]  mem_wdata;
	logic [2:0]  joypad_out;
	logic [1:0]  joypad_clock;

	logic [31:0] lfsr_state = 32'h4f18;
	int          clk_count = 0;
	int          ce_gap = 0;
	logic        ce_seen = 1'b0;
	int          spr_count = 0;    // Sprite reads seen in the current copy
	int          dmc_count = 0;
	logic        read_pending = 1'b0; // Sprite read waiting for its $2004 write
	logic [7:0]  spr_page = 8'h00;
	logic [7:0]  exp_byte = 8'h00;
	logic [15:0] dmc_addr_exp = 16'h0000;

	nes_bus_top dut (.*);

	always #10 clk = ~clk;

	// Memory returns low byte XOR high byte of the address
	function automatic logic [7:0] mem_value(input logic [15:0] a);
		return a[7:0] ^ a[15:8];
	endfunction
	assign mem_din = mem_value(mem_addr);

	// Fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v = {v[14:0], fb};
		end
		return v;
	endfunction

	task automatic stop_failed;
		$display("Result: FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("FAILED at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
		stop_failed();
	endtask

	task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act == exp) else value_error(name, exp, act);
	endtask

	// One CPU bus cycle, repeated while the DMA holds the CPU
	task automatic cpu_access(input logic [15:0] addr, input logic rnw, input logic [7:0] wdata,
			output logic [7:0] rdata);
		logic done;
		cpu_addr = addr;
		cpu_rnw  = rnw;
		cpu_dout = wdata;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			done  = cpu_ce && !pause_cpu;
			rdata = cpu_din;
			@(posedge clk);
		end
		#2;
	endtask

	// Request one DMC byte and release the trigger after the ack cycle
	task automatic dmc_request;
		dmc_addr_exp = 16'hC000 | rand_bits(14); // DMC sample area
		dmc_dma_addr = dmc_addr_exp;
		dmc_trigger  = 1'b1;
		do @(negedge clk); while (!(dmc_ack && cpu_ce));
		@(posedge clk);
		#2 dmc_trigger = 1'b0;
	endtask

	task automatic sprite_copy(input logic with_dmc);
		logic [15:0] r;
		logic [7:0]  dummy;
		r = rand_bits(5); // Pages $00-$1F keep the source in RAM
		spr_page = r[7:0];
		spr_count = 0;
		dmc_count = 0;
		cpu_access(OAM_DMA_ADDR, 1'b0, spr_page, dummy);
		check_equal("pause_cpu", 1, pause_cpu);
		fork
			cpu_access(16'h8123, 1'b1, 8'h00, dummy); // Held until the copy ends
			if (with_dmc) begin
				wait (spr_count == 100); // Steal a cycle mid-copy
				@(posedge clk);
				#2 dmc_request();
			end
		join
		check_equal("sprite reads", 256, spr_count);
		check_equal("read_pending", 0, read_pending); // Last $2004 write done
		check_equal("dmc reads", with_dmc, dmc_count);
	endtask

	// Bus monitor at the end of each CPU cycle
	always @(negedge clk) begin
		if (!reset) begin
			ce_gap++;
			if (cpu_ce) begin
				if (ce_seen) check_equal("cpu_ce period", 12, ce_gap);
				ce_seen = 1'b1;
				ce_gap  = 0;
				if (dmc_ack) begin
					check_equal("mem_addr", dmc_addr_exp, mem_addr);
					dmc_count++;
				end else if (read_pending) begin
					check_equal("mem_write", 1, mem_write);
					check_equal("mem_addr", OAM_DATA_ADDR, mem_addr);
					check_equal("mem_wdata", exp_byte, mem_wdata);
					read_pending = 1'b0;
				end else if (pause_cpu && mem_read && mem_addr[15:13] == 3'b000) begin
					check_equal("mem_addr", {spr_page, spr_count[7:0]}, mem_addr);
					exp_byte = mem_value(mem_addr);
					read_pending = 1'b1;
					spr_count++;
				end else if (pause_cpu && mem_write) begin
					$display("A write appeared during DMA without a sprite read before it");
					stop_failed();
				end
			end
		end
	end

	// DMC address must own the bus for the whole ack
	dmc_bus_check: assert property (@(posedge clk) disable iff (reset)
		dmc_ack |-> (mem_addr == dmc_dma_addr && mem_read))
		else value_error("mem_addr", dmc_dma_addr, mem_addr);

	always @(posedge clk) begin
		clk_count++;
		if (clk_count >= TIMEOUT_CLKS) begin
			$display("Timeout: the run did not finish within %0d clocks", TIMEOUT_CLKS);
			stop_failed();
		end
	end

	initial begin
		int          n;
		int          i;
		logic [15:0] r;
		logic [15:0] a;
		logic [7:0]  v;
		logic [7:0]  prev;
		logic [7:0]  got;
		reset = 1'b1;
		cpu_addr = 16'h8000;
		cpu_rnw = 1'b1;
		cpu_dout = 8'h00;
		dmc_trigger = 1'b0;
		dmc_dma_addr = 16'hC000;
		joypad1_data = 5'h00;
		joypad2_data = 5'h00;
		repeat (5) @(posedge clk);
		#2 reset = 1'b0;
		@(posedge clk); // First edge with reset low
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n == 1) begin
				check_equal("pause_cpu", 0, pause_cpu);
				check_equal("dmc_ack", 0, dmc_ack);
				check_equal("mem_write", 0, mem_write);
				check_equal("joypad_clock", 0, joypad_clock);
				check_equal("joypad_out", 0, joypad_out);
			end
		end while (!cpu_ce && n < 20);
		check_equal("first cpu_ce delay", 11, n);
		@(posedge clk);
		#2 sprite_copy(1'b0);
		// DMC fetch while the CPU reads
		dmc_count = 0;
		fork
			for (i = 0; i < 8; i++) begin
				cpu_access(16'h8000 + i, 1'b1, 8'h00, got);
				check_equal("cpu_din", mem_value(16'h8000 + i), got);
			end
			begin
				repeat (13) @(posedge clk);
				#2 dmc_request();
			end
		join
		check_equal("dmc reads", 1, dmc_count);
		sprite_copy(1'b1);
		// Joypad strobe, clocks and open-bus upper bits
		r = rand_bits(8);
		v = r[7:0];
		cpu_access(JOY1_ADDR, 1'b0, v, got);
		cpu_access(16'h8000, 1'b1, 8'h00, got); // At least one put edge passes
		check_equal("joypad_out", v[2:0], joypad_out);
		r = rand_bits(5);
		joypad1_data = r[4:0];
		r = rand_bits(5);
		joypad2_data = r[4:0];
		r = rand_bits(8);
		a = {8'h07, r[7:0]};
		cpu_access(a, 1'b1, 8'h00, prev);
		check_equal("cpu_din", mem_value(a), prev);
		cpu_access(JOY1_ADDR, 1'b1, 8'h00, got);
		check_equal("joypad_clock", 2'b01, joypad_clock);
		check_equal("cpu_din", {prev[7:5], joypad1_data}, got);
		prev = got;
		cpu_access(JOY2_ADDR, 1'b1, 8'h00, got);
		check_equal("joypad_clock", 2'b10, joypad_clock);
		check_equal("cpu_din", {prev[7:5], joypad2_data}, got);
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: vlog.f
rtl/nes_bus_pkg.sv
rtl/cpu_clock_gen.sv
rtl/sprite_dmc_dma.sv
rtl/cpu_bus_mux.sv
rtl/nes_bus_top.sv
tb/tb_nes_bus.sv

// File: Bender.yml
package:
  name: nes_bus

sources:
  - rtl/nes_bus_pkg.sv
  - rtl/cpu_clock_gen.sv
  - rtl/sprite_dmc_dma.sv
  - rtl/cpu_bus_mux.sv
  - rtl/nes_bus_top.sv
  - target: test
    files:
      - tb/tb_nes_bus.sv
